/* source/dma_pkg.sv */
package dma_pkg;

  // register bus
  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // address bits 13:12 pick the page, the low 12 bits are the offset
  localparam int PAGE_W = 12;
  localparam int NUM_PAGES = 3;

  typedef logic [1:0] page_t;
  typedef logic [PAGE_W-1:0] reg_off_t;

  localparam page_t PAGE_H2S    = 2'd0;
  localparam page_t PAGE_S2H    = 2'd1;
  localparam page_t PAGE_GLOBAL = 2'd2;

  // channel page offsets
  localparam reg_off_t REG_ADDR   = 12'h000;
  localparam reg_off_t REG_LEN    = 12'h004;
  localparam reg_off_t REG_GO     = 12'h008;
  localparam reg_off_t REG_STATUS = 12'h00c;

  // global page offsets
  localparam reg_off_t REG_CACHE    = 12'h000;
  localparam reg_off_t REG_SOFT_RST = 12'h004;
  localparam reg_off_t REG_ID       = 12'h008;

  // ------------------------------
  // command layout, datamover style
  // ------------------------------
  localparam int TAG_W  = 4;
  localparam int BTT_W  = 23;
  localparam int DATA_W = 64;

  // fields of a REG_GO write
  localparam int GO_EOF_BIT = 0;
  localparam int GO_TAG_LSB = 4;

  typedef struct packed {
    logic [3:0]       rsvd_hi;
    logic [TAG_W-1:0] tag;
    logic [31:0]      addr;
    logic             rsvd_drr;
    logic             eof;
    logic [6:0]       rsvd_lo;
    logic [BTT_W-1:0] btt;
  } cmd_t;

  typedef logic [7:0] sts_t;

  typedef struct packed {
    logic              last;
    logic [DATA_W-1:0] data;
  } beat_t;

  localparam reg_data_t UNMAPPED_DATA = 32'hdeadbeef;
  localparam reg_data_t ID_VALUE      = 32'h0d3a_0100;

  // default queue depths, the top passes them down
  localparam int DEF_CMD_DEPTH  = 4;
  localparam int DEF_STS_DEPTH  = 4;
  localparam int DEF_LOOP_DEPTH = 16;

endpackage

/* source/page_decode.sv */
`timescale 1ns/1ps

module page_decode import dma_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 set_stb,
  input  reg_addr_t            set_addr,
  input  logic                 get_stb,
  input  reg_addr_t            get_addr,
  output logic [NUM_PAGES-1:0] set_stb_page,
  output logic [NUM_PAGES-1:0] get_stb_page,
  output page_t                get_page_q
);

  page_t set_page;
  page_t get_page;

  assign set_page = set_addr[PAGE_W+1:PAGE_W];
  assign get_page = get_addr[PAGE_W+1:PAGE_W];

  // page 3 has no strobe at all
  always_comb begin
    for (int i = 0; i < NUM_PAGES; i++) begin
      set_stb_page[i] = set_stb && (set_page == page_t'(i));
      get_stb_page[i] = get_stb && (get_page == page_t'(i));
    end
  end

  // read_return muxes one cycle later, keep the page of that read
  always_ff @(posedge clk) begin
    if (rst) begin
      get_page_q <= PAGE_H2S;
    end else if (get_stb) begin
      get_page_q <= get_page;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(set_stb_page) && $onehot0(get_stb_page))
    else $error("page_decode: strobe hits more than one page");

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  payload_t                   push_data,
  output logic                       full,
  input  logic                       pop,
  output payload_t                   pop_data,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // wrap explicitly so depths other than a power of two work
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  // show-ahead, the head is visible while not empty
  assign pop_data = mem[rd_ptr];
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);

  // callers gate their strobes with full and empty
  assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("sync_fifo: push while full");
  assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("sync_fifo: pop while empty");

endmodule

/* source/stream_channel.sv */
`timescale 1ns/1ps

module stream_channel import dma_pkg::*; #(
  parameter int DEPTH_CMD = 4,
  parameter int DEPTH_STS = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      set_stb,
  input  reg_addr_t set_addr,
  input  reg_data_t set_data,
  input  logic      get_stb,
  input  reg_addr_t get_addr,
  output reg_data_t get_data,
  output logic      cmd_valid,
  output cmd_t      cmd_data,
  input  logic      cmd_ready,
  input  logic      sts_valid,
  input  sts_t      sts_data,
  output logic      sts_ready,
  output logic      sts_pending
);

  localparam int CMD_CNT_W = $clog2(DEPTH_CMD+1);
  localparam int STS_CNT_W = $clog2(DEPTH_STS+1);

  logic [31:0]          addr_q;
  logic [BTT_W-1:0]     len_q;
  logic [TAG_W-1:0]     tag_q;
  logic                 overflow_q;
  logic                 go_wr;
  logic                 cmd_push;
  logic                 cmd_full;
  logic                 cmd_empty;
  logic [CMD_CNT_W-1:0] cmd_count;
  cmd_t                 go_cmd;
  logic                 sts_push;
  logic                 sts_pop;
  logic                 sts_full;
  logic                 sts_empty;
  logic [STS_CNT_W-1:0] sts_count;
  sts_t                 sts_head;

  // ------------------------------
  // command composer
  // ------------------------------
  assign go_wr    = set_stb && (set_addr[PAGE_W-1:0] == REG_GO);
  assign cmd_push = go_wr && !cmd_full;

  // tag from the GO word is an offset on the running tag
  always_comb begin
    go_cmd      = '0;
    go_cmd.addr = addr_q;
    go_cmd.btt  = len_q;
    go_cmd.tag  = set_data[GO_TAG_LSB +: TAG_W] + tag_q;
    go_cmd.eof  = set_data[GO_EOF_BIT];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q     <= '0;
      len_q      <= '0;
      tag_q      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (set_stb && (set_addr[PAGE_W-1:0] == REG_ADDR)) addr_q <= set_data;
      if (set_stb && (set_addr[PAGE_W-1:0] == REG_LEN)) len_q <= set_data[BTT_W-1:0];
      if (cmd_push) tag_q <= tag_q + 1'b1;
      // sticky until reset
      if (go_wr && cmd_full) overflow_q <= 1'b1;
    end
  end

  sync_fifo #(.payload_t(cmd_t), .DEPTH(DEPTH_CMD)) u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_push),
    .push_data (go_cmd),
    .full      (cmd_full),
    .pop       (cmd_valid && cmd_ready),
    .pop_data  (cmd_data),
    .empty     (cmd_empty),
    .count     (cmd_count)
  );

  assign cmd_valid = !cmd_empty;

  // ------------------------------
  // status queue
  // ------------------------------
  assign sts_ready = !sts_full;
  assign sts_push  = sts_valid && sts_ready;
  // reading REG_STATUS consumes the head byte
  assign sts_pop   = get_stb && (get_addr[PAGE_W-1:0] == REG_STATUS) && !sts_empty;

  sync_fifo #(.payload_t(sts_t), .DEPTH(DEPTH_STS)) u_sts_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (sts_push),
    .push_data (sts_data),
    .full      (sts_full),
    .pop       (sts_pop),
    .pop_data  (sts_head),
    .empty     (sts_empty),
    .count     (sts_count)
  );

  assign sts_pending = !sts_empty;

  always_comb begin
    case (get_addr[PAGE_W-1:0])
      REG_ADDR:   get_data = addr_q;
      REG_LEN:    get_data = {{(32-BTT_W){1'b0}}, len_q};
      REG_GO:     get_data = {{(32-TAG_W){1'b0}}, tag_q};
      REG_STATUS: get_data = {15'b0, overflow_q, 4'(cmd_count), 4'(sts_count),
                              sts_empty ? 8'h00 : sts_head};
      default:    get_data = UNMAPPED_DATA;
    endcase
  end

endmodule

/* source/global_settings.sv */
`timescale 1ns/1ps

module global_settings import dma_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       set_stb,
  input  reg_addr_t  set_addr,
  input  reg_data_t  set_data,
  input  reg_addr_t  get_addr,
  output reg_data_t  get_data,
  output logic [3:0] arcache,
  output logic [3:0] awcache,
  output logic       soft_reset
);

  logic [7:0] cache_q;
  reg_off_t   set_off;
  reg_off_t   get_off;

  assign set_off = set_addr[PAGE_W-1:0];
  assign get_off = get_addr[PAGE_W-1:0];

  // cache attributes survive a soft reset, only rst clears them
  always_ff @(posedge clk) begin
    if (rst) begin
      cache_q <= 8'h33;
    end else if (set_stb && (set_off == REG_CACHE)) begin
      cache_q <= set_data[7:0];
    end
  end

  assign arcache = cache_q[3:0];
  assign awcache = cache_q[7:4];

  // one cycle pulse, the data word is ignored
  always_ff @(posedge clk) begin
    if (rst) begin
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= set_stb && (set_off == REG_SOFT_RST);
    end
  end

  always_comb begin
    case (get_off)
      REG_CACHE:    get_data = {24'b0, cache_q};
      REG_SOFT_RST: get_data = '0;
      REG_ID:       get_data = ID_VALUE;
      default:      get_data = UNMAPPED_DATA;
    endcase
  end

endmodule

/* source/loopback_path.sv */
`timescale 1ns/1ps

module loopback_path import dma_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  input  logic              in_last,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_ready,
  input  logic              cmd_accept
);

  logic                       active_q;
  logic                       full;
  logic                       empty;
  logic                       pop;
  beat_t                      in_beat;
  beat_t                      head;

  assign in_beat.data = in_data;
  assign in_beat.last = in_last;
  assign in_ready     = !full;

  // the output only opens between an s2h command and its last beat
  assign out_valid = !empty && active_q;
  assign pop       = out_valid && out_ready;
  assign out_data  = head.data;
  assign out_last  = head.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
    end else if (cmd_accept) begin
      active_q <= 1'b1;
    end else if (pop && head.last) begin
      active_q <= 1'b0;
    end
  end

  sync_fifo #(.payload_t(beat_t), .DEPTH(DEPTH)) u_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid && in_ready),
    .push_data (in_beat),
    .full      (full),
    .pop       (pop),
    .pop_data  (head),
    .empty     (empty),
    .count     ()
  );

endmodule

/* source/read_return.sv */
`timescale 1ns/1ps

module read_return import dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      get_stb,
  input  page_t     get_page_q,
  input  reg_data_t h2s_data,
  input  reg_data_t s2h_data,
  input  reg_data_t global_data,
  input  logic      h2s_pending,
  input  logic      s2h_pending,
  output reg_data_t get_data,
  output logic      get_valid,
  output logic      irq
);

  reg_data_t h2s_q;
  reg_data_t s2h_q;
  reg_data_t global_q;

  // capture every page word with the strobe, the page arrives registered too
  always_ff @(posedge clk) begin
    if (get_stb) begin
      h2s_q    <= h2s_data;
      s2h_q    <= s2h_data;
      global_q <= global_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) get_valid <= 1'b0;
    else get_valid <= get_stb;
  end

  always_comb begin
    case (get_page_q)
      PAGE_H2S:    get_data = h2s_q;
      PAGE_S2H:    get_data = s2h_q;
      PAGE_GLOBAL: get_data = global_q;
      default:     get_data = UNMAPPED_DATA;
    endcase
  end

  // one shared interrupt for both directions
  assign irq = h2s_pending | s2h_pending;

endmodule

/* source/dma_ctrl_top.sv */
`timescale 1ns/1ps

module dma_ctrl_top import dma_pkg::*; #(
  parameter int CMD_DEPTH  = DEF_CMD_DEPTH,
  parameter int STS_DEPTH  = DEF_STS_DEPTH,
  parameter int LOOP_DEPTH = DEF_LOOP_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  // register bus
  input  logic              set_stb,
  input  reg_addr_t         set_addr,
  input  reg_data_t         set_data,
  input  logic              get_stb,
  input  reg_addr_t         get_addr,
  output reg_data_t         get_data,
  output logic              get_valid,
  // commands
  output logic              h2s_cmd_valid,
  output cmd_t              h2s_cmd_data,
  input  logic              h2s_cmd_ready,
  output logic              s2h_cmd_valid,
  output cmd_t              s2h_cmd_data,
  input  logic              s2h_cmd_ready,
  // status
  input  logic              h2s_sts_valid,
  input  sts_t              h2s_sts_data,
  output logic              h2s_sts_ready,
  input  logic              s2h_sts_valid,
  input  sts_t              s2h_sts_data,
  output logic              s2h_sts_ready,
  // loopback stream
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  input  logic              in_last,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_ready,
  output logic              irq,
  output logic [3:0]        arcache,
  output logic [3:0]        awcache
);

  logic [NUM_PAGES-1:0] set_stb_page;
  logic [NUM_PAGES-1:0] get_stb_page;
  page_t                get_page_q;
  reg_data_t            h2s_get_data;
  reg_data_t            s2h_get_data;
  reg_data_t            global_get_data;
  logic                 h2s_pending;
  logic                 s2h_pending;
  logic                 soft_reset;
  logic                 rst_chan;

  // soft reset clears queues and loopback but not the settings page
  assign rst_chan = rst || soft_reset;

  page_decode u_decode (
    .clk(clk), .rst(rst),
    .set_stb(set_stb), .set_addr(set_addr),
    .get_stb(get_stb), .get_addr(get_addr),
    .set_stb_page(set_stb_page), .get_stb_page(get_stb_page),
    .get_page_q(get_page_q)
  );

  stream_channel #(.DEPTH_CMD(CMD_DEPTH), .DEPTH_STS(STS_DEPTH)) u_h2s (
    .clk(clk), .rst(rst_chan),
    .set_stb(set_stb_page[PAGE_H2S]), .set_addr(set_addr), .set_data(set_data),
    .get_stb(get_stb_page[PAGE_H2S]), .get_addr(get_addr), .get_data(h2s_get_data),
    .cmd_valid(h2s_cmd_valid), .cmd_data(h2s_cmd_data), .cmd_ready(h2s_cmd_ready),
    .sts_valid(h2s_sts_valid), .sts_data(h2s_sts_data), .sts_ready(h2s_sts_ready),
    .sts_pending(h2s_pending)
  );

  stream_channel #(.DEPTH_CMD(CMD_DEPTH), .DEPTH_STS(STS_DEPTH)) u_s2h (
    .clk(clk), .rst(rst_chan),
    .set_stb(set_stb_page[PAGE_S2H]), .set_addr(set_addr), .set_data(set_data),
    .get_stb(get_stb_page[PAGE_S2H]), .get_addr(get_addr), .get_data(s2h_get_data),
    .cmd_valid(s2h_cmd_valid), .cmd_data(s2h_cmd_data), .cmd_ready(s2h_cmd_ready),
    .sts_valid(s2h_sts_valid), .sts_data(s2h_sts_data), .sts_ready(s2h_sts_ready),
    .sts_pending(s2h_pending)
  );

  global_settings u_global (
    .clk(clk), .rst(rst),
    .set_stb(set_stb_page[PAGE_GLOBAL]), .set_addr(set_addr), .set_data(set_data),
    .get_addr(get_addr), .get_data(global_get_data),
    .arcache(arcache), .awcache(awcache), .soft_reset(soft_reset)
  );

  loopback_path #(.DEPTH(LOOP_DEPTH)) u_loop (
    .clk(clk), .rst(rst_chan),
    .in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_ready(in_ready),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
    .out_ready(out_ready),
    .cmd_accept(s2h_cmd_valid && s2h_cmd_ready)
  );

  read_return u_read (
    .clk(clk), .rst(rst),
    .get_stb(get_stb), .get_page_q(get_page_q),
    .h2s_data(h2s_get_data), .s2h_data(s2h_get_data), .global_data(global_get_data),
    .h2s_pending(h2s_pending), .s2h_pending(s2h_pending),
    .get_data(get_data), .get_valid(get_valid), .irq(irq)
  );

endmodule

/* dv/tb_dma_ctrl.sv */
`timescale 1ns/1ps

module tb_dma_ctrl import dma_pkg::*; ();

  localparam int CMD_DEPTH  = 4;
  localparam int STS_DEPTH  = 4;
  localparam int LOOP_DEPTH = 16;

  // row operations
  localparam int OP_WR       = 0;
  localparam int OP_RD       = 1;
  localparam int OP_GO       = 2;
  localparam int OP_CMD      = 3;
  localparam int OP_STS      = 4;
  localparam int OP_STSRD    = 5;
  localparam int OP_IRQ      = 6;
  localparam int OP_CACHE    = 7;
  localparam int OP_BEAT     = 8;
  localparam int OP_OUT_TAKE = 9;
  localparam int OP_OUT_SHUT = 10;
  localparam int OP_SRST     = 11;

  typedef struct {
    int          op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [71:0] exp;
  } row_t;

  logic        clk;
  logic        rst;
  logic        set_stb;
  logic [31:0] set_addr;
  logic [31:0] set_data;
  logic        get_stb;
  logic [31:0] get_addr;
  logic [31:0] get_data;
  logic        get_valid;
  logic        h2s_cmd_valid;
  logic [71:0] h2s_cmd_data;
  logic        h2s_cmd_ready;
  logic        s2h_cmd_valid;
  logic [71:0] s2h_cmd_data;
  logic        s2h_cmd_ready;
  logic        h2s_sts_valid;
  logic [7:0]  h2s_sts_data;
  logic        h2s_sts_ready;
  logic        s2h_sts_valid;
  logic [7:0]  s2h_sts_data;
  logic        s2h_sts_ready;
  logic        in_valid;
  logic [63:0] in_data;
  logic        in_last;
  logic        in_ready;
  logic        out_valid;
  logic [63:0] out_data;
  logic        out_last;
  logic        out_ready;
  logic        irq;
  logic [3:0]  arcache;
  logic [3:0]  awcache;

  row_t        rows[$];
  logic        rows_ready;
  int          errors;
  int          checks;
  int          errs_before;
  logic [15:0] lfsr_q;

  // reference state of both channels and the loopback FIFO
  logic [31:0] addr_m [2];
  logic [22:0] len_m [2];
  logic [3:0]  tag_m [2];
  logic        ovf_m [2];
  logic [71:0] h2s_cmd_m[$];
  logic [71:0] s2h_cmd_m[$];
  logic [7:0]  h2s_sts_m[$];
  logic [7:0]  s2h_sts_m[$];
  logic [64:0] beat_m[$];

  dma_ctrl_top #(
    .CMD_DEPTH(CMD_DEPTH), .STS_DEPTH(STS_DEPTH), .LOOP_DEPTH(LOOP_DEPTH)
  ) dut (
    .clk(clk), .rst(rst),
    .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
    .get_stb(get_stb), .get_addr(get_addr), .get_data(get_data), .get_valid(get_valid),
    .h2s_cmd_valid(h2s_cmd_valid), .h2s_cmd_data(h2s_cmd_data),
    .h2s_cmd_ready(h2s_cmd_ready),
    .s2h_cmd_valid(s2h_cmd_valid), .s2h_cmd_data(s2h_cmd_data),
    .s2h_cmd_ready(s2h_cmd_ready),
    .h2s_sts_valid(h2s_sts_valid), .h2s_sts_data(h2s_sts_data),
    .h2s_sts_ready(h2s_sts_ready),
    .s2h_sts_valid(s2h_sts_valid), .s2h_sts_data(s2h_sts_data),
    .s2h_sts_ready(s2h_sts_ready),
    .in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_ready(in_ready),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
    .out_ready(out_ready),
    .irq(irq), .arcache(arcache), .awcache(awcache)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // 4 reserved, tag, addr, 1 reserved, eof, 7 reserved, byte count
  function automatic logic [71:0] expect_cmd(input logic [3:0] tag, input logic [31:0] addr,
                                             input logic eof, input logic [22:0] btt);
    return {4'b0, tag, addr, 1'b0, eof, 7'b0, btt};
  endfunction

  function automatic void add_row(input int op, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [71:0] exp);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    rows.push_back(r);
  endfunction

  function automatic logic cmd_valid_of(input logic ch);
    return ch ? s2h_cmd_valid : h2s_cmd_valid;
  endfunction

  function automatic logic [71:0] cmd_data_of(input logic ch);
    return ch ? s2h_cmd_data : h2s_cmd_data;
  endfunction

  task automatic check(input string name, input logic [71:0] exp, input logic [71:0] act);
    checks++;
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic fail_note(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge clk);
    set_stb  <= 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [71:0] exp, input string name);
    @(posedge clk);
    get_stb  <= 1'b1;
    get_addr <= addr;
    @(negedge clk);
    if (get_valid) fail_note("get_valid high in the same cycle as get_stb");
    @(posedge clk);
    get_stb <= 1'b0;
    @(negedge clk);
    if (!get_valid) fail_note("get_valid missing one cycle after get_stb");
    check(name, exp, 72'(get_data));
  endtask

  task automatic take_cmd(input logic ch, input int hold);
    logic [71:0] exp;
    int          waited;
    if ((ch ? s2h_cmd_m.size() : h2s_cmd_m.size()) == 0) begin
      fail_note("command requested but none is queued in the model");
      return;
    end
    exp = ch ? s2h_cmd_m.pop_front() : h2s_cmd_m.pop_front();
    waited = 0;
    @(negedge clk);
    while (!cmd_valid_of(ch) && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_valid_of(ch)) begin
      fail_note("timed out waiting for cmd_valid");
      return;
    end
    check("cmd_data", exp, cmd_data_of(ch));
    // ready held low, the command must stay put
    repeat (hold) begin
      @(negedge clk);
      if (!cmd_valid_of(ch)) fail_note("cmd_valid dropped while cmd_ready was low");
      check("cmd_data", exp, cmd_data_of(ch));
    end
    @(posedge clk);
    if (ch) s2h_cmd_ready <= 1'b1;
    else h2s_cmd_ready <= 1'b1;
    @(posedge clk);
    if (ch) s2h_cmd_ready <= 1'b0;
    else h2s_cmd_ready <= 1'b0;
  endtask

  task automatic push_sts(input logic ch);
    logic [7:0] b;
    logic       room;
    int         waited;
    b = 8'(rand_bits(8));
    room = (ch ? s2h_sts_m.size() : h2s_sts_m.size()) < STS_DEPTH;
    waited = 0;
    @(posedge clk);
    if (ch) begin
      s2h_sts_valid <= 1'b1;
      s2h_sts_data  <= b;
    end else begin
      h2s_sts_valid <= 1'b1;
      h2s_sts_data  <= b;
    end
    @(negedge clk);
    // ready follows the free space in the status queue
    if (ch) check("s2h_sts_ready", 72'(room), 72'(s2h_sts_ready));
    else check("h2s_sts_ready", 72'(room), 72'(h2s_sts_ready));
    while (room && !(ch ? s2h_sts_ready : h2s_sts_ready) && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    h2s_sts_valid <= 1'b0;
    s2h_sts_valid <= 1'b0;
    if (room && waited >= 50) fail_note("sts_ready never rose");
    else if (room && ch) s2h_sts_m.push_back(b);
    else if (room) h2s_sts_m.push_back(b);
  endtask

  task automatic push_beat(input logic last);
    logic [63:0] d;
    logic        room;
    int          waited;
    d = rand_bits(64);
    room = beat_m.size() < LOOP_DEPTH;
    waited = 0;
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= d;
    in_last  <= last;
    @(negedge clk);
    // a full loopback FIFO refuses the beat
    check("in_ready", 72'(room), 72'(in_ready));
    while (room && !in_ready && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    if (room && waited >= 50) fail_note("in_ready never rose");
    else if (room) beat_m.push_back({last, d});
  endtask

  task automatic take_beats();
    logic [64:0] b;
    logic        done;
    int          waited;
    done = 1'b0;
    waited = 0;
    @(posedge clk);
    out_ready <= 1'b1;
    while (!done && waited < 100) begin
      @(negedge clk);
      if (out_valid) begin
        if (beat_m.size() == 0) begin
          fail_note("beat appeared at the output with none expected");
          done = 1'b1;
        end else begin
          b = beat_m.pop_front();
          check("out_data", 72'(b[63:0]), 72'(out_data));
          check("out_last", 72'(b[64]), 72'(out_last));
          done = b[64];
        end
      end
      waited++;
      @(posedge clk);
    end
    out_ready <= 1'b0;
    if (!done) fail_note("timed out waiting for the last beat");
  endtask

  task automatic run_row(input row_t r);
    logic ch;
    logic was_empty;
    ch = r.addr[12];
    case (r.op)
      OP_WR: begin
        write_reg(r.addr, r.data);
        if (r.addr[13] == 1'b0 && r.addr[11:0] == REG_ADDR) addr_m[ch] = r.data;
        if (r.addr[13] == 1'b0 && r.addr[11:0] == REG_LEN) len_m[ch] = r.data[22:0];
      end
      OP_RD: read_reg(r.addr, r.exp, "get_data");
      OP_GO: begin
        was_empty = (ch ? s2h_cmd_m.size() : h2s_cmd_m.size()) == 0;
        if ((ch ? s2h_cmd_m.size() : h2s_cmd_m.size()) < CMD_DEPTH) begin
          if (ch) s2h_cmd_m.push_back(expect_cmd(tag_m[ch], addr_m[ch], r.data[0], len_m[ch]));
          else h2s_cmd_m.push_back(expect_cmd(tag_m[ch], addr_m[ch], r.data[0], len_m[ch]));
          tag_m[ch] = tag_m[ch] + 4'd1;
        end else begin
          ovf_m[ch] = 1'b1;
        end
        write_reg(r.addr, r.data);
        if (was_empty) begin
          @(negedge clk);
          if (!cmd_valid_of(ch)) fail_note("cmd_valid not raised one cycle after GO");
        end
      end
      OP_CMD: take_cmd(ch, int'(r.data));
      OP_STS: push_sts(ch);
      OP_STSRD: begin
        if (ch) begin
          read_reg(r.addr, 72'({15'b0, ovf_m[1], 4'(s2h_cmd_m.size()), 4'(s2h_sts_m.size()),
                   (s2h_sts_m.size() > 0) ? s2h_sts_m[0] : 8'h00}), "get_data");
          if (s2h_sts_m.size() > 0) void'(s2h_sts_m.pop_front());
        end else begin
          read_reg(r.addr, 72'({15'b0, ovf_m[0], 4'(h2s_cmd_m.size()), 4'(h2s_sts_m.size()),
                   (h2s_sts_m.size() > 0) ? h2s_sts_m[0] : 8'h00}), "get_data");
          if (h2s_sts_m.size() > 0) void'(h2s_sts_m.pop_front());
        end
      end
      OP_IRQ: begin
        @(negedge clk);
        check("irq", r.exp, 72'(irq));
      end
      OP_CACHE: begin
        @(negedge clk);
        check("awcache/arcache", r.exp, 72'({awcache, arcache}));
      end
      OP_BEAT: push_beat(r.data[0]);
      OP_OUT_TAKE: take_beats();
      OP_OUT_SHUT: begin
        @(posedge clk);
        out_ready <= 1'b1;
        repeat (4) begin
          @(negedge clk);
          if (out_valid) fail_note("loopback output open without an s2h command");
        end
        @(posedge clk);
        out_ready <= 1'b0;
      end
      OP_SRST: begin
        write_reg(32'h0000_2004, r.data);
        // the pulse resets the channels on the following edge
        @(posedge clk);
        for (int i = 0; i < 2; i++) begin
          addr_m[i] = '0;
          len_m[i]  = '0;
          tag_m[i]  = '0;
          ovf_m[i]  = 1'b0;
        end
        h2s_cmd_m.delete();
        s2h_cmd_m.delete();
        h2s_sts_m.delete();
        s2h_sts_m.delete();
        beat_m.delete();
      end
      default: fail_note("unknown table operation");
    endcase
  endtask

  // ------------------------------
  // table
  // ------------------------------
  task automatic build_table();
    // global page and unmapped page
    add_row(OP_WR, 32'h0000_2000, 32'h0000_005a, 72'h0);
    add_row(OP_RD, 32'h0000_2000, 32'h0, 72'h5a);
    add_row(OP_CACHE, 32'h0, 32'h0, 72'h5a);
    add_row(OP_RD, 32'h0000_2008, 32'h0, 72'(ID_VALUE));
    add_row(OP_RD, 32'h0000_3000, 32'h0, 72'(UNMAPPED_DATA));
    add_row(OP_RD, 32'h0000_3ffc, 32'h0, 72'(UNMAPPED_DATA));
    // h2s commands, fifth GO overflows
    add_row(OP_WR, 32'h0000_0000, 32'h1000_0000, 72'h0);
    add_row(OP_WR, 32'h0000_0004, 32'h0000_0100, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h1, 72'h0);
    add_row(OP_WR, 32'h0000_0000, 32'h1000_0100, 72'h0);
    add_row(OP_WR, 32'h0000_0004, 32'h007f_fff8, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h0, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h1, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h0, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h1, 72'h0);
    add_row(OP_STSRD, 32'h0000_000c, 32'h0, 72'h0);
    add_row(OP_CMD, 32'h0000_0000, 32'd3, 72'h0);
    add_row(OP_CMD, 32'h0000_0000, 32'd0, 72'h0);
    add_row(OP_CMD, 32'h0000_0000, 32'd2, 72'h0);
    add_row(OP_CMD, 32'h0000_0000, 32'd0, 72'h0);
    add_row(OP_STSRD, 32'h0000_000c, 32'h0, 72'h0);
    // loopback gate
    // sixteen beats fill the FIFO and the next one is refused
    for (int i = 0; i < LOOP_DEPTH; i++) begin
      add_row(OP_BEAT, 32'h0, (i == LOOP_DEPTH - 1) ? 32'h1 : 32'h0, 72'h0);
    end
    add_row(OP_BEAT, 32'h0, 32'h0, 72'h0);
    add_row(OP_OUT_SHUT, 32'h0, 32'h0, 72'h0);
    add_row(OP_WR, 32'h0000_1000, 32'h2000_0000, 72'h0);
    add_row(OP_WR, 32'h0000_1004, 32'h0000_0018, 72'h0);
    add_row(OP_GO, 32'h0000_1008, 32'h1, 72'h0);
    add_row(OP_CMD, 32'h0000_1000, 32'd1, 72'h0);
    add_row(OP_OUT_TAKE, 32'h0, 32'h0, 72'h0);
    add_row(OP_BEAT, 32'h0, 32'h0, 72'h0);
    add_row(OP_BEAT, 32'h0, 32'h1, 72'h0);
    add_row(OP_OUT_SHUT, 32'h0, 32'h0, 72'h0);
    add_row(OP_GO, 32'h0000_1008, 32'h0, 72'h0);
    add_row(OP_CMD, 32'h0000_1000, 32'd0, 72'h0);
    add_row(OP_OUT_TAKE, 32'h0, 32'h0, 72'h0);
    // status bytes and irq
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h0);
    add_row(OP_STS, 32'h0000_0000, 32'h0, 72'h0);
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h1);
    add_row(OP_STS, 32'h0000_0000, 32'h0, 72'h0);
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    add_row(OP_STSRD, 32'h0000_000c, 32'h0, 72'h0);
    add_row(OP_STSRD, 32'h0000_000c, 32'h0, 72'h0);
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h1);
    add_row(OP_STSRD, 32'h0000_100c, 32'h0, 72'h0);
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h0);
    // soft reset
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    // the fifth s2h status byte finds the queue full
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    add_row(OP_STS, 32'h0000_1000, 32'h0, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h0, 72'h0);
    add_row(OP_GO, 32'h0000_0008, 32'h1, 72'h0);
    add_row(OP_BEAT, 32'h0, 32'h1, 72'h0);
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h1);
    add_row(OP_SRST, 32'h0, 32'h0, 72'h0);
    add_row(OP_IRQ, 32'h0, 32'h0, 72'h0);
    add_row(OP_STSRD, 32'h0000_000c, 32'h0, 72'h0);
    add_row(OP_STSRD, 32'h0000_100c, 32'h0, 72'h0);
    add_row(OP_CACHE, 32'h0, 32'h0, 72'h5a);
    add_row(OP_RD, 32'h0000_2000, 32'h0, 72'h5a);
    add_row(OP_GO, 32'h0000_1008, 32'h0, 72'h0);
    add_row(OP_CMD, 32'h0000_1000, 32'd0, 72'h0);
    add_row(OP_OUT_SHUT, 32'h0, 32'h0, 72'h0);
    add_row(OP_BEAT, 32'h0, 32'h1, 72'h0);
    add_row(OP_OUT_TAKE, 32'h0, 32'h0, 72'h0);
  endtask

  initial begin
    rows_ready = 1'b0;
    wait (rows_ready);
    repeat (rows.size() * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles", rows.size() * 200);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    set_stb = 1'b0;
    set_addr = '0;
    set_data = '0;
    get_stb = 1'b0;
    get_addr = '0;
    h2s_cmd_ready = 1'b0;
    s2h_cmd_ready = 1'b0;
    h2s_sts_valid = 1'b0;
    h2s_sts_data = '0;
    s2h_sts_valid = 1'b0;
    s2h_sts_data = '0;
    in_valid = 1'b0;
    in_data = '0;
    in_last = 1'b0;
    out_ready = 1'b0;
    errors = 0;
    checks = 0;
    lfsr_q = 16'd8053;
    for (int i = 0; i < 2; i++) begin
      addr_m[i] = '0;
      len_m[i]  = '0;
      tag_m[i]  = '0;
      ovf_m[i]  = 1'b0;
    end
    build_table();
    rows_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      errs_before = errors;
      run_row(rows[i]);
      if (errors == errs_before) $display("row %0d op %0d ok", i, rows[i].op);
      else $display("row %0d op %0d failed, %0d errors", i, rows[i].op, errors - errs_before);
    end
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
source/dma_pkg.sv
source/page_decode.sv
source/sync_fifo.sv
source/stream_channel.sv
source/global_settings.sv
source/loopback_path.sv
source/read_return.sv
source/dma_ctrl_top.sv
dv/tb_dma_ctrl.sv

/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dma_ctrl: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dma_ctrl \
		-f src.f -o Vtb_dma_ctrl

run: obj_dir/Vtb_dma_ctrl
	./obj_dir/Vtb_dma_ctrl > sim.log 2>&1; cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
